/* list.f */
+incdir+include
hdl/core_pkg.sv
hdl/core_regfile.sv
hdl/core_ifu.sv
hdl/core_idu.sv
hdl/core_exu.sv
hdl/core_lsu.sv
hdl/core_wbu.sv
hdl/core_top.sv
verif/core_tb_asserts.sv
verif/core_tb.sv

/* include/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Instruction memory depth in 32-bit words
// Fetch addresses must stay below IMEM_WORDS * 4
`define IMEM_WORDS 256

`endif

/* verif/core_tb.sv */
`default_nettype none

`include "core_defs.svh"

module core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMEM_IDX_W   = $clog2(`IMEM_WORDS);
    localparam int RESET_CYCLES = 10;
    localparam int COMMIT_WAIT  = 12;
    localparam int COMMIT_GAP   = 6;
    // Instructions over all five tests
    localparam int TOTAL_INSTS  = 32;
    localparam int NUM_TESTS    = 5;
    localparam int MAX_CYCLES   = TOTAL_INSTS * COMMIT_GAP
                                  + NUM_TESTS * (RESET_CYCLES + COMMIT_WAIT) + 100;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] imem_addr;
    logic [31:0]     imem_rdata;
    logic            commit_valid;
    commit_t         commit;

    logic [31:0]     imem [`IMEM_WORDS];
    // Architectural register values the program should leave behind
    logic [31:0]     xr [32];
    commit_t         exp_q [$];
    logic [XLEN-1:0] cur_pc;
    logic [31:0]     lfsr_state = 32'hcd422f88;
    int              cycles = 0;
    int              errors = 0;

    core_top u_dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .imem_addr_o    (imem_addr),
        .imem_rdata_i   (imem_rdata),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    assign imem_rdata = imem[imem_addr[IMEM_IDX_W+1:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("Run timed out after %0d cycles", cycles);
        $display("Check errors: %0d, assertion failures: %0d",
                 errors, u_dut.u_asserts.fail_count);
        $display("Some tests failed");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    // rd and wdata only mean something when the commit writes
    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got.pc !== exp.pc) report_mismatch("commit_o.pc", got.pc, exp.pc);
        if (got.we !== exp.we) report_mismatch("commit_o.we", 32'(got.we), 32'(exp.we));
        if (got.next_pc !== exp.next_pc) begin
            report_mismatch("commit_o.next_pc", got.next_pc, exp.next_pc);
        end
        if (exp.we) begin
            if (got.rd !== exp.rd) report_mismatch("commit_o.rd", 32'(got.rd), 32'(exp.rd));
            if (got.wdata !== exp.wdata) report_mismatch("commit_o.wdata", got.wdata, exp.wdata);
        end
    endtask

    function automatic void fill_imem();
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            // Unknown opcode tagged with the word index
            imem[i] = {i[24:0], 7'b1111111};
        end
    endfunction

    task automatic clear_program();
        @(posedge clk);
        #1;
        fill_imem();
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        exp_q.delete();
        cur_pc = RESET_PC;
    endtask

    task automatic emit(input logic [31:0] inst, input int rd, input logic [31:0] wdata,
                        input logic writes, input logic [31:0] next_pc);
        commit_t exp;
        exp.pc      = cur_pc;
        exp.rd      = rd[4:0];
        exp.wdata   = wdata;
        exp.we      = writes && (rd != 0);
        exp.next_pc = next_pc;
        imem[cur_pc[IMEM_IDX_W+1:2]] = inst;
        if (exp.we) xr[rd] = wdata;
        exp_q.push_back(exp);
        cur_pc = next_pc;
    endtask

    task automatic addi(input int rd, input int rs1, input logic [31:0] imm);
        emit(i_type(imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM), rd,
             xr[rs1] + {{20{imm[11]}}, imm[11:0]}, 1'b1, cur_pc + 32'd4);
    endtask

    task automatic op_r(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                        input int rs1, input int rs2, input logic [31:0] value);
        emit(r_type(f7, rs2[4:0], rs1[4:0], f3, rd[4:0]), rd, value, 1'b1, cur_pc + 32'd4);
    endtask

    task automatic load(input int rd, input int rs1, input logic [31:0] off,
                        input logic [31:0] value);
        emit(i_type(off[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD), rd, value, 1'b1,
             cur_pc + 32'd4);
    endtask

    task automatic store(input int rs2, input int rs1, input logic [31:0] off);
        emit(s_type(off[11:0], rs2[4:0], rs1[4:0]), 0, '0, 1'b0, cur_pc + 32'd4);
    endtask

    task automatic branch(input logic [2:0] f3, input int rs1, input int rs2, input int off);
        logic [31:0] off_w;
        logic        taken;
        off_w = off;
        // BEQ takes on equal operands, BNE on different ones
        taken = (f3 == 3'b000) ? (xr[rs1] == xr[rs2]) : (xr[rs1] != xr[rs2]);
        emit(b_type(off_w[12:0], rs2[4:0], rs1[4:0], f3), 0, '0, 1'b0,
             taken ? cur_pc + off_w : cur_pc + 32'd4);
    endtask

    task automatic jal(input int rd, input int off);
        logic [31:0] off_w;
        off_w = off;
        emit(j_type(off_w[20:0], rd[4:0]), rd, cur_pc + 32'd4, 1'b1, cur_pc + off_w);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic run_program(input string name);
        commit_t exp;
        int      waited;
        int      last_cycle;
        apply_reset();
        last_cycle = -1;
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!commit_valid && waited < COMMIT_WAIT);
            if (!commit_valid) begin
                $display("%s: no commit from pc %h within %0d cycles", name, exp.pc, waited);
                errors++;
                exp_q.delete();
            end else begin
                check_commit(commit, exp);
                if (last_cycle >= 0 && cycles - last_cycle != COMMIT_GAP) begin
                    $display("%s: commits %0d cycles apart instead of %0d",
                             name, cycles - last_cycle, COMMIT_GAP);
                    errors++;
                end
                last_cycle = cycles;
            end
        end
    endtask

    task automatic alu_ops();
        clear_program();
        addi(1, 0, rand_bits(12));
        addi(2, 0, rand_bits(12));
        addi(1, 1, rand_bits(12));
        op_r(7'h00, 3'b000, 3, 1, 2, xr[1] + xr[2]);
        op_r(7'h20, 3'b000, 4, 1, 2, xr[1] - xr[2]);
        op_r(7'h00, 3'b111, 5, 1, 2, xr[1] & xr[2]);
        op_r(7'h00, 3'b110, 6, 1, 2, xr[1] | xr[2]);
        op_r(7'h00, 3'b100, 7, 4, 3, xr[4] ^ xr[3]);
        emit(u_type(20'h8badf, 5'd8), 8, 32'h8badf000, 1'b1, cur_pc + 32'd4);
        run_program("alu");
    endtask

    task automatic x0_writes();
        clear_program();
        addi(0, 0, rand_bits(12));
        // Sees the old x0 through rs1
        addi(9, 0, 32'd7);
        run_program("x0");
    endtask

    task automatic load_store();
        logic [31:0] base;
        clear_program();
        base = rand_bits(6) << 2;
        addi(1, 0, base);
        addi(2, 0, rand_bits(12));
        addi(3, 0, rand_bits(12));
        store(2, 1, 32'd0);
        store(3, 1, 32'd8);
        load(4, 1, 32'd0, xr[2]);
        load(5, 1, 32'd8, xr[3]);
        store(3, 1, 32'd0);
        load(6, 1, 32'd0, xr[3]);
        run_program("load_store");
    endtask

    task automatic branches();
        logic [31:0] v;
        clear_program();
        v = rand_bits(12);
        addi(1, 0, v);
        addi(2, 0, v);
        addi(3, 0, v ^ 32'd1);
        branch(3'b000, 1, 2, 8);
        branch(3'b000, 1, 3, 8);
        branch(3'b001, 1, 3, 12);
        branch(3'b001, 1, 2, 8);
        addi(4, 1, 32'd1);
        run_program("branch");
    endtask

    task automatic jal_and_unknown();
        logic [31:0] junk;
        clear_program();
        junk = rand_bits(25);
        jal(1, 16);
        // custom-0 opcode retires as a no-operation
        emit({junk[24:0], 7'b0001011}, 0, '0, 1'b0, cur_pc + 32'd4);
        jal(0, 8);
        addi(2, 1, 32'd0);
        run_program("jal_unknown");
    endtask

    initial begin
        rst_n = 1'b1;
        fill_imem();
        #1;
        rst_n = 1'b0;
        alu_ops();
        x0_writes();
        load_store();
        branches();
        jal_and_unknown();
        $display("Check errors: %0d, assertion failures: %0d",
                 errors, u_dut.u_asserts.fail_count);
        if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/core_tb_asserts.sv */
`default_nettype none

`include "core_defs.svh"

module core_tb_asserts import core_pkg::*; (
    input wire logic            clk,
    input wire logic            rst_n_i,
    input wire logic [XLEN-1:0] imem_addr_i,
    input wire logic            commit_valid_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // One instruction in flight, so commits never come back to back
    commit_gap: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |=> !commit_valid_i)
        else begin
            fail_count++;
            $error("commit_valid_o high in two consecutive cycles");
        end

    fetch_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        (imem_addr_i[1:0] == 2'b00) && (imem_addr_i < `IMEM_WORDS * 4))
        else begin
            fail_count++;
            $error("imem_addr_o misaligned or outside instruction memory");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> !commit_valid_i)
        else begin
            fail_count++;
            $error("commit_valid_o high during reset");
        end

endmodule

bind core_top core_tb_asserts u_asserts (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .imem_addr_i    (imem_addr_o),
    .commit_valid_i (commit_valid_o)
);

`default_nettype wire

/* hdl/core_top.sv */
`default_nettype none

module core_top import core_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n_i,
    output logic      [XLEN-1:0] imem_addr_o,
    input  wire logic [31:0]     imem_rdata_i,
    output logic                 commit_valid_o,
    output commit_t              commit_o
);

    fetch_t                fetch;
    logic                  fetch_valid;
    decode_t               decode;
    logic                  decode_valid;
    exec_t                 exec;
    logic                  exec_valid;
    mem_t                  mem;
    logic                  mem_valid;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;

    core_regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    core_ifu u_ifu (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .imem_addr_o      (imem_addr_o),
        .imem_rdata_i     (imem_rdata_i),
        .fetch_valid_o    (fetch_valid),
        .fetch_o          (fetch)
    );

    core_idu u_idu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid),
        .fetch_i        (fetch),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .decode_valid_o (decode_valid),
        .decode_o       (decode)
    );

    core_exu u_exu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .decode_valid_i (decode_valid),
        .decode_i       (decode),
        .exec_valid_o   (exec_valid),
        .exec_o         (exec)
    );

    core_lsu u_lsu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .exec_valid_i (exec_valid),
        .exec_i       (exec),
        .mem_valid_o  (mem_valid),
        .mem_o        (mem)
    );

    // Write-back also closes the PC loop back to fetch
    core_wbu u_wbu (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .mem_valid_i      (mem_valid),
        .mem_i            (mem),
        .rf_we_o          (rf_we),
        .rf_waddr_o       (rf_waddr),
        .rf_wdata_o       (rf_wdata),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .commit_valid_o   (commit_valid_o),
        .commit_o         (commit_o)
    );

endmodule

`default_nettype wire

/* hdl/core_wbu.sv */
`default_nettype none

module core_wbu import core_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  mem_valid_i,
    input  wire mem_t                  mem_i,
    output logic                       rf_we_o,
    output logic      [REG_ADDR_W-1:0] rf_waddr_o,
    output logic      [XLEN-1:0]       rf_wdata_o,
    output logic                       redirect_valid_o,
    output logic      [XLEN-1:0]       redirect_pc_o,
    output logic                       commit_valid_o,
    output commit_t                    commit_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rf_we_o        <= 1'b0;
            commit_valid_o <= 1'b0;
        end else begin
            rf_we_o        <= mem_valid_i && mem_i.reg_write;
            commit_valid_o <= mem_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid_i) begin
            commit_o.pc      <= mem_i.pc;
            commit_o.rd      <= mem_i.rd;
            commit_o.wdata   <= mem_i.wdata;
            // Matches what the register file keeps
            commit_o.we      <= mem_i.reg_write && (mem_i.rd != '0);
            commit_o.next_pc <= mem_i.next_pc;
        end
    end

    // Register write and redirect share the commit cycle
    assign rf_waddr_o       = commit_o.rd;
    assign rf_wdata_o       = commit_o.wdata;
    assign redirect_valid_o = commit_valid_o;
    assign redirect_pc_o    = commit_o.next_pc;

endmodule

`default_nettype wire

/* hdl/core_lsu.sv */
`default_nettype none

module core_lsu import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  exec_valid_i,
    input  wire exec_t exec_i,
    output logic       mem_valid_o,
    output mem_t       mem_o
);

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;

    // Word index, low address bits dropped and upper bits wrapped
    assign word_idx = exec_i.result[DMEM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (exec_valid_i && exec_i.is_store) begin
            dmem[word_idx] <= exec_i.store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_valid_o <= 1'b0;
        end else begin
            mem_valid_o <= exec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid_i) begin
            mem_o.pc        <= exec_i.pc;
            mem_o.rd        <= exec_i.rd;
            mem_o.reg_write <= exec_i.reg_write;
            mem_o.next_pc   <= exec_i.next_pc;
            if (exec_i.is_load) begin
                mem_o.wdata <= dmem[word_idx];
            end else begin
                mem_o.wdata <= exec_i.result;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/core_exu.sv */
`default_nettype none

module core_exu import core_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n_i,
    input  wire logic    decode_valid_i,
    input  wire decode_t decode_i,
    output logic         exec_valid_o,
    output exec_t        exec_o
);

    logic [XLEN-1:0] alu_result;
    logic            taken;
    logic [XLEN-1:0] next_pc;

    always_comb begin
        case (decode_i.alu_op)
            ALU_ADD:    alu_result = decode_i.op1 + decode_i.op2;
            ALU_SUB:    alu_result = decode_i.op1 - decode_i.op2;
            ALU_AND:    alu_result = decode_i.op1 & decode_i.op2;
            ALU_OR:     alu_result = decode_i.op1 | decode_i.op2;
            ALU_XOR:    alu_result = decode_i.op1 ^ decode_i.op2;
            ALU_PASS_B: alu_result = decode_i.op2;
            default:    alu_result = '0;
        endcase
    end

    // Equality test, flipped for BNE
    assign taken = decode_i.is_branch
                   && ((decode_i.op1 == decode_i.rs2_data) ^ decode_i.branch_ne);

    assign next_pc = (taken || decode_i.is_jal) ? decode_i.target : decode_i.pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exec_valid_o <= 1'b0;
        end else begin
            exec_valid_o <= decode_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_valid_i) begin
            exec_o.pc         <= decode_i.pc;
            exec_o.result     <= alu_result;
            exec_o.store_data <= decode_i.rs2_data;
            exec_o.rd         <= decode_i.rd;
            exec_o.next_pc    <= next_pc;
            exec_o.is_load    <= decode_i.is_load;
            exec_o.is_store   <= decode_i.is_store;
            exec_o.reg_write  <= decode_i.reg_write;
        end
    end

endmodule

`default_nettype wire

/* hdl/core_idu.sv */
`default_nettype none

module core_idu import core_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  fetch_valid_i,
    input  wire fetch_t                fetch_i,
    output logic      [REG_ADDR_W-1:0] rs1_addr_o,
    output logic      [REG_ADDR_W-1:0] rs2_addr_o,
    input  wire logic [XLEN-1:0]       rs1_data_i,
    input  wire logic [XLEN-1:0]       rs2_data_i,
    output logic                       decode_valid_o,
    output decode_t                    decode_o
);

    logic [31:0]     inst;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    decode_t         dec;

    assign inst   = fetch_i.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        dec.pc       = fetch_i.pc;
        dec.rd       = inst[11:7];
        dec.rs2_data = rs2_data_i;
        dec.alu_op   = ALU_ADD;
        dec.target   = fetch_i.pc + ((opcode == OPC_JAL) ? imm_j : imm_b);
        dec.op1      = rs1_data_i;
        case (opcode)
            OPC_OP: begin
                dec.op2       = rs2_data_i;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // Only ADDI among the immediate ALU forms
                dec.op2       = imm_i;
                dec.reg_write = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                dec.op1       = '0;
                dec.op2       = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec.op2       = imm_i;
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_STORE: begin
                dec.op2      = imm_s;
                dec.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                dec.op2       = rs2_data_i;
                dec.is_branch = (funct3[2:1] == 2'b00);
                dec.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                // Link value comes out of the ALU as pc + 4
                dec.op1       = fetch_i.pc;
                dec.op2       = 32'd4;
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: dec.op1 = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            decode_valid_o <= 1'b0;
        end else begin
            decode_valid_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i) begin
            decode_o <= dec;
        end
    end

endmodule

`default_nettype wire

/* hdl/core_ifu.sv */
`default_nettype none

module core_ifu import core_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n_i,
    input  wire logic            redirect_valid_i,
    input  wire logic [XLEN-1:0] redirect_pc_i,
    output logic      [XLEN-1:0] imem_addr_o,
    input  wire logic [31:0]     imem_rdata_i,
    output logic                 fetch_valid_o,
    output fetch_t               fetch_o
);

    typedef enum logic {
        FETCH,
        WAIT
    } state_e;

    state_e          state;
    logic [XLEN-1:0] pc;

    assign imem_addr_o = pc;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state         <= FETCH;
            pc            <= RESET_PC;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            if (state == FETCH) begin
                fetch_valid_o <= 1'b1;
                state         <= WAIT;
            end else if (redirect_valid_i) begin
                // Write-back closes the loop with the next PC
                pc    <= redirect_pc_i;
                state <= FETCH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            fetch_o.pc   <= pc;
            fetch_o.inst <= imem_rdata_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/core_regfile.sv */
`default_nettype none

module core_regfile import core_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic [REG_ADDR_W-1:0] raddr1_i,
    input  wire logic [REG_ADDR_W-1:0] raddr2_i,
    output logic      [XLEN-1:0]       rdata1_o,
    output logic      [XLEN-1:0]       rdata2_o,
    input  wire logic                  we_i,
    input  wire logic [REG_ADDR_W-1:0] waddr_i,
    input  wire logic [XLEN-1:0]       wdata_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } fetch_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  branch_ne;
        logic                  is_jal;
        logic                  reg_write;
        logic [XLEN-1:0]       target;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       next_pc;
        logic                  is_load;
        logic                  is_store;
        logic                  reg_write;
    } exec_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       wdata;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic [XLEN-1:0]       next_pc;
    } mem_t;

    // Retired instruction as seen from outside the core
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  we;
        logic [XLEN-1:0]       next_pc;
    } commit_t;

endpackage

`default_nettype wire
